/* buffer_cfg_pkg.sv */
// ------------------------------
// sizing constants shared by the sample buffer datapath
// import wherever memory, channel or count widths are needed
// ------------------------------
`default_nettype none

package buffer_cfg_pkg;

  // number of input channels on the tagged stream
  localparam int n_channels = 4;

  // bits per sample and per output word
  localparam int sample_width = 16;

  // the shared memory is split evenly between enabled channels
  localparam int mem_depth = 128;
  localparam int addr_width = 7;

  localparam int chan_width = 2;

  // one bit wider than the address so a full region count fits
  localparam int count_width = 8;

endpackage

`default_nettype wire

/* buffer_types_pkg.sv */
// ------------------------------
// enumerated types for banking mode and control FSMs
// ------------------------------
`default_nettype none

package buffer_types_pkg;

  // mode m enables channels 0 to 2^m-1
  typedef enum logic [1:0] {
    mode_one  = 2'd0,
    mode_two  = 2'd1,
    mode_four = 2'd2
  } bank_mode_e;

  typedef enum logic [1:0] {
    wr_idle,
    wr_capture,
    wr_done
  } writer_state_e;

  typedef enum logic [2:0] {
    rd_idle,
    rd_hdr_chan,
    rd_hdr_count,
    rd_samples,
    rd_finish
  } reader_state_e;

endpackage

`default_nettype wire

/* mem_port_if.sv */
// ------------------------------
// request/grant port between a memory client and the arbiter
// read data returns with rvalid one cycle after the grant
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
  import buffer_cfg_pkg::*;

  // driven by the client
  logic                    req;
  logic                    we;
  logic [addr_width-1:0]   addr;
  logic [sample_width-1:0] wdata;

  // driven by the arbiter
  logic                    gnt;
  logic                    rvalid;
  logic [sample_width-1:0] rdata;

  modport master (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

`default_nettype wire

/* sample_memory.sv */
// ------------------------------
// single-port sample RAM with registered read data
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_memory (
  input  logic                                   clk,
  input  logic                                   en_i,
  input  logic                                   we_i,
  input  logic [buffer_cfg_pkg::addr_width-1:0]   addr_i,
  input  logic [buffer_cfg_pkg::sample_width-1:0] wdata_i,
  output logic [buffer_cfg_pkg::sample_width-1:0] rdata_o
);
  import buffer_cfg_pkg::*;

  logic [sample_width-1:0] ram_q [mem_depth];

  // read data appears the cycle after an enabled read
  // and holds until the next one
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        ram_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= ram_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
// ------------------------------
// round-robin arbiter putting writer or reader onto the RAM
// read data is steered back to whichever port issued the read
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic                                   clk,
  input  logic                                   reset_i,
  mem_port_if.arbiter                            writer,
  mem_port_if.arbiter                            reader,
  output logic                                   ram_en_o,
  output logic                                   ram_we_o,
  output logic [buffer_cfg_pkg::addr_width-1:0]   ram_addr_o,
  output logic [buffer_cfg_pkg::sample_width-1:0] ram_wdata_o,
  input  logic [buffer_cfg_pkg::sample_width-1:0] ram_rdata_i
);

  // set when the reader won the most recent grant
  logic last_rd_q;
  logic gnt_wr;
  logic gnt_rd;
  logic rd_valid_q;
  logic rd_owner_q;

  // on contention the port that lost last time goes first
  assign gnt_wr = writer.req && (!reader.req || last_rd_q);
  assign gnt_rd = reader.req && !gnt_wr;

  assign writer.gnt = gnt_wr;
  assign reader.gnt = gnt_rd;

  assign ram_en_o    = gnt_wr || gnt_rd;
  assign ram_we_o    = gnt_rd ? reader.we : writer.we;
  assign ram_addr_o  = gnt_rd ? reader.addr : writer.addr;
  assign ram_wdata_o = gnt_rd ? reader.wdata : writer.wdata;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      last_rd_q  <= 1'b0;
      rd_valid_q <= 1'b0;
      rd_owner_q <= 1'b0;
    end else begin
      if (ram_en_o) begin
        last_rd_q <= gnt_rd;
      end
      // remember who owns the read that returns next cycle
      rd_valid_q <= ram_en_o && !ram_we_o;
      rd_owner_q <= gnt_rd;
    end
  end

  assign writer.rvalid = rd_valid_q && !rd_owner_q;
  assign reader.rvalid = rd_valid_q && rd_owner_q;
  assign writer.rdata  = ram_rdata_i;
  assign reader.rdata  = ram_rdata_i;

endmodule

`default_nettype wire

/* capture_writer.sv */
// ------------------------------
// capture control and sample writes into the banked memory
// holds the mode and per-channel counts until readout finishes
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module capture_writer (
  input  logic                                   clk,
  input  logic                                   reset_i,
  input  buffer_types_pkg::bank_mode_e           mode_i,
  input  logic                                   mode_valid_i,
  output logic                                   mode_ready_o,
  input  logic                                   start_i,
  input  logic                                   stop_i,
  input  logic                                   in_valid_i,
  output logic                                   in_ready_o,
  input  logic [buffer_cfg_pkg::chan_width-1:0]   in_channel_i,
  input  logic [buffer_cfg_pkg::sample_width-1:0] in_data_i,
  input  logic                                   readout_done_i,
  mem_port_if.master                             mem,
  output logic                                   capture_done_o,
  output buffer_types_pkg::bank_mode_e           mode_o,
  output logic [buffer_cfg_pkg::n_channels-1:0][buffer_cfg_pkg::count_width-1:0] counts_o,
  output logic                                   capture_active_o
);
  import buffer_cfg_pkg::*;
  import buffer_types_pkg::*;

  writer_state_e                               state_q;
  bank_mode_e                                  mode_q;
  logic [n_channels-1:0][count_width-1:0]      counts_q;
  logic                                        pend_valid_q;
  logic [chan_width-1:0]                       pend_chan_q;
  logic [sample_width-1:0]                     pend_data_q;
  logic [count_width-1:0]                      region_size;
  logic                                        chan_en;
  logic                                        fill_now;
  logic                                        accept_write;

  assign region_size = count_width'(mem_depth >> mode_q);
  assign chan_en     = (in_channel_i >> mode_q) == '0;

  // this grant writes the last free word of a region
  assign fill_now = mem.gnt && (counts_q[pend_chan_q] + 1'b1 == region_size);

  // a new sample can enter in the same cycle the pending one is granted
  assign in_ready_o   = !pend_valid_q || mem.gnt;
  assign accept_write = in_valid_i && in_ready_o && (state_q == wr_capture) &&
                        !stop_i && !fill_now && chan_en;

  // address is region base plus the channel's count at grant time
  assign mem.req   = pend_valid_q;
  assign mem.we    = 1'b1;
  assign mem.wdata = pend_data_q;
  assign mem.addr  = addr_width'({pend_chan_q, {addr_width{1'b0}}} >> mode_q) +
                     addr_width'(counts_q[pend_chan_q]);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q        <= wr_idle;
      mode_q         <= mode_one;
      counts_q       <= '0;
      pend_valid_q   <= 1'b0;
      capture_done_o <= 1'b0;
    end else begin
      capture_done_o <= 1'b0;
      if (mode_valid_i && mode_ready_o) begin
        mode_q <= mode_i;
      end
      if (mem.gnt) begin
        counts_q[pend_chan_q] <= counts_q[pend_chan_q] + 1'b1;
      end
      if (accept_write) begin
        pend_valid_q <= 1'b1;
      end else if (mem.gnt) begin
        pend_valid_q <= 1'b0;
      end
      case (state_q)
        wr_idle: begin
          if (start_i) begin
            state_q  <= wr_capture;
            counts_q <= '0;
          end
        end
        wr_capture: begin
          if (stop_i || fill_now) begin
            state_q        <= wr_done;
            capture_done_o <= 1'b1;
          end
        end
        wr_done: begin
          if (readout_done_i) begin
            state_q <= wr_idle;
          end
        end
        default: state_q <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept_write) begin
      pend_chan_q <= in_channel_i;
      pend_data_q <= in_data_i;
    end
  end

  assign mode_ready_o     = state_q == wr_idle;
  assign capture_active_o = state_q == wr_capture;
  assign mode_o           = mode_q;
  assign counts_o         = counts_q;

endmodule

`default_nettype wire

/* readout_reader.sv */
// ------------------------------
// readout sequencer producing header and sample words per channel
// words leave through a two-entry skid FIFO under back-pressure
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module readout_reader (
  input  logic                                   clk,
  input  logic                                   reset_i,
  input  logic                                   capture_done_i,
  input  buffer_types_pkg::bank_mode_e           mode_i,
  input  logic [buffer_cfg_pkg::n_channels-1:0][buffer_cfg_pkg::count_width-1:0] counts_i,
  mem_port_if.master                             mem,
  output logic                                   readout_done_o,
  output logic                                   out_valid_o,
  input  logic                                   out_ready_i,
  output logic [buffer_cfg_pkg::sample_width-1:0] out_data_o,
  output logic                                   out_last_o
);
  import buffer_cfg_pkg::*;
  import buffer_types_pkg::*;

  reader_state_e           state_q;
  reader_state_e           after_chan;
  logic [chan_width-1:0]   chan_q;
  logic [chan_width-1:0]   last_chan;
  logic [count_width-1:0]  idx_q;
  logic [count_width-1:0]  chan_count;
  logic                    is_last_chan;
  logic                    rd_last_q;
  logic                    hdr_push;
  logic                    hdr_last;
  logic                    push;
  logic                    pop;
  logic [sample_width-1:0] push_data;
  logic                    push_last;
  logic [sample_width-1:0] fifo_data_q [2];
  logic                    fifo_last_q [2];
  logic                    wr_ptr_q;
  logic                    rd_ptr_q;
  logic [1:0]              fifo_count_q;

  assign last_chan    = chan_width'((1 << mode_i) - 1);
  assign is_last_chan = chan_q == last_chan;
  assign chan_count   = counts_i[chan_q];
  assign after_chan   = is_last_chan ? rd_finish : rd_hdr_chan;

  // headers wait for any read still returning from the previous channel
  assign hdr_push = ((state_q == rd_hdr_chan) || (state_q == rd_hdr_count)) &&
                    !mem.rvalid && (fifo_count_q != 2'd2);
  assign hdr_last = (state_q == rd_hdr_count) && (chan_count == '0) && is_last_chan;

  // only reads that are sure to find a free entry are issued
  assign mem.req   = (state_q == rd_samples) && (fifo_count_q + 2'(mem.rvalid) <= 2'd1);
  assign mem.we    = 1'b0;
  assign mem.wdata = '0;
  assign mem.addr  = addr_width'({chan_q, {addr_width{1'b0}}} >> mode_i) +
                     addr_width'(idx_q);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= rd_idle;
      chan_q  <= '0;
      idx_q   <= '0;
    end else begin
      case (state_q)
        rd_idle: begin
          if (capture_done_i) begin
            chan_q  <= '0;
            state_q <= rd_hdr_chan;
          end
        end
        rd_hdr_chan: begin
          if (hdr_push) begin
            state_q <= rd_hdr_count;
          end
        end
        rd_hdr_count: begin
          if (hdr_push) begin
            idx_q <= '0;
            if (chan_count == '0) begin
              chan_q  <= chan_q + 1'b1;
              state_q <= after_chan;
            end else begin
              state_q <= rd_samples;
            end
          end
        end
        rd_samples: begin
          if (mem.gnt) begin
            idx_q <= idx_q + 1'b1;
            if (idx_q + 1'b1 == chan_count) begin
              chan_q  <= chan_q + 1'b1;
              state_q <= after_chan;
            end
          end
        end
        rd_finish: begin
          if (readout_done_o) begin
            state_q <= rd_idle;
          end
        end
        default: state_q <= rd_idle;
      endcase
    end
  end

  // tags the returning read as the final output word
  always_ff @(posedge clk) begin
    if (mem.gnt) begin
      rd_last_q <= is_last_chan && (idx_q + 1'b1 == chan_count);
    end
  end

  assign push      = mem.rvalid || hdr_push;
  assign push_data = mem.rvalid ? mem.rdata :
                     (state_q == rd_hdr_chan) ? sample_width'(chan_q) :
                     sample_width'(chan_count);
  assign push_last = mem.rvalid ? rd_last_q : hdr_last;
  assign pop       = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q     <= 1'b0;
      rd_ptr_q     <= 1'b0;
      fifo_count_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      fifo_count_q <= fifo_count_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_data_q[wr_ptr_q] <= push_data;
      fifo_last_q[wr_ptr_q] <= push_last;
    end
  end

  assign out_valid_o    = fifo_count_q != '0;
  assign out_data_o     = fifo_data_q[rd_ptr_q];
  assign out_last_o     = out_valid_o && fifo_last_q[rd_ptr_q];
  assign readout_done_o = (state_q == rd_finish) && pop && out_last_o;

endmodule

`default_nettype wire

/* sample_buffer.sv */
// ------------------------------
// banked sample capture buffer top level
// captures a tagged sample stream and reads it out per channel
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_buffer (
  input  logic                                   clk,
  input  logic                                   reset_i,
  input  buffer_types_pkg::bank_mode_e           mode_i,
  input  logic                                   mode_valid_i,
  output logic                                   mode_ready_o,
  input  logic                                   start_i,
  input  logic                                   stop_i,
  input  logic                                   in_valid_i,
  output logic                                   in_ready_o,
  input  logic [buffer_cfg_pkg::chan_width-1:0]   in_channel_i,
  input  logic [buffer_cfg_pkg::sample_width-1:0] in_data_i,
  output logic                                   out_valid_o,
  input  logic                                   out_ready_i,
  output logic [buffer_cfg_pkg::sample_width-1:0] out_data_o,
  output logic                                   out_last_o,
  output logic                                   capture_active_o
);
  import buffer_cfg_pkg::*;
  import buffer_types_pkg::*;

  logic                                   capture_done;
  logic                                   readout_done;
  bank_mode_e                             cap_mode;
  logic [n_channels-1:0][count_width-1:0] counts;
  logic                                   ram_en;
  logic                                   ram_we;
  logic [addr_width-1:0]                  ram_addr;
  logic [sample_width-1:0]                ram_wdata;
  logic [sample_width-1:0]                ram_rdata;

  mem_port_if wr_port ();
  mem_port_if rd_port ();

  capture_writer u_capture_writer (
    .clk              (clk),
    .reset_i          (reset_i),
    .mode_i           (mode_i),
    .mode_valid_i     (mode_valid_i),
    .mode_ready_o     (mode_ready_o),
    .start_i          (start_i),
    .stop_i           (stop_i),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .in_channel_i     (in_channel_i),
    .in_data_i        (in_data_i),
    .readout_done_i   (readout_done),
    .mem              (wr_port),
    .capture_done_o   (capture_done),
    .mode_o           (cap_mode),
    .counts_o         (counts),
    .capture_active_o (capture_active_o)
  );

  readout_reader u_readout_reader (
    .clk            (clk),
    .reset_i        (reset_i),
    .capture_done_i (capture_done),
    .mode_i         (cap_mode),
    .counts_i       (counts),
    .mem            (rd_port),
    .readout_done_o (readout_done),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .out_data_o     (out_data_o),
    .out_last_o     (out_last_o)
  );

  mem_arbiter u_mem_arbiter (
    .clk         (clk),
    .reset_i     (reset_i),
    .writer      (wr_port),
    .reader      (rd_port),
    .ram_en_o    (ram_en),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .ram_rdata_i (ram_rdata)
  );

  sample_memory u_sample_memory (
    .clk     (clk),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

/* sample_buffer_tb.sv */
// ------------------------------
// self-checking testbench for the banked sample buffer
// runs a table of capture scenarios against a reference model
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_buffer_tb;
  import buffer_types_pkg::*;

  localparam int n_rows = 8;

  logic        clk = 1'b0;
  logic        reset_i;
  bank_mode_e  mode_i;
  logic        mode_valid_i;
  logic        mode_ready_o;
  logic        start_i;
  logic        stop_i;
  logic        in_valid_i;
  logic        in_ready_o;
  logic [1:0]  in_channel_i;
  logic [15:0] in_data_i;
  logic        out_valid_o;
  logic        out_ready_i;
  logic [15:0] out_data_o;
  logic        out_last_o;
  logic        capture_active_o;

  // one row per scenario with the region size in words per enabled channel
  string row_name     [n_rows] = '{"stop_one", "stop_two", "stop_four", "fill_one",
                                   "overfill_gaps_four", "ready_toggle_two",
                                   "gaps_toggle_four", "overfill_toggle_two"};
  int    row_mode     [n_rows] = '{0, 1, 2, 0, 2, 1, 2, 1};
  int    row_per_chan [n_rows] = '{4, 5, 6, 130, 40, 20, 10, 70};
  bit    row_gaps     [n_rows] = '{0, 0, 0, 0, 1, 0, 1, 1};
  bit    row_toggle   [n_rows] = '{0, 0, 0, 0, 0, 1, 1, 1};
  bit    row_stop     [n_rows] = '{1, 1, 1, 0, 0, 1, 1, 0};
  int    row_region   [n_rows] = '{128, 64, 32, 128, 32, 64, 32, 64};

  int    seed = 57220;
  string test_name;
  bit    started;
  int    cycle_cnt = 0;
  int    fill_cycle;

  // reference model keeps each channel's stored samples in arrival order
  logic [15:0] model_mem [4][128];
  int          model_cnt [4];
  bit          model_full;
  logic [15:0] exp_q [$];

  sample_buffer u_sample_buffer (
    .clk              (clk),
    .reset_i          (reset_i),
    .mode_i           (mode_i),
    .mode_valid_i     (mode_valid_i),
    .mode_ready_o     (mode_ready_o),
    .start_i          (start_i),
    .stop_i           (stop_i),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .in_channel_i     (in_channel_i),
    .in_data_i        (in_data_i),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i),
    .out_data_o       (out_data_o),
    .out_last_o       (out_last_o),
    .capture_active_o (capture_active_o)
  );

  always #2 clk = ~clk;

  // counts rising edges so the end of capture can be timed after a fill
  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // capture stops filling as soon as any enabled channel is full
  task automatic record_sample(input int ch, input logic [15:0] val, input int row);
    if (!model_full && ch < (1 << row_mode[row])) begin
      model_mem[ch][model_cnt[ch]] = val;
      model_cnt[ch]++;
      if (model_cnt[ch] == row_region[row]) begin
        model_full = 1'b1;
        fill_cycle = cycle_cnt;
      end
    end
  endtask

  task automatic apply_mode(input bank_mode_e mode);
    @(posedge clk);
    #1;
    mode_i = mode;
    mode_valid_i = 1'b1;
    @(negedge clk);
    check_value("mode_ready before mode", 1, int'(mode_ready_o));
    @(posedge clk);
    #1;
    mode_valid_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      in_valid_i = 1'b0;
    end
  endtask

  // holds the sample until the handshake completes
  task automatic send_sample(input int ch, input logic [15:0] val, input int row);
    bit taken;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      #1;
      in_valid_i   = 1'b1;
      in_channel_i = 2'(ch);
      in_data_i    = val;
      @(negedge clk);
      check_value("mode_ready while sending", started ? 0 : 1, int'(mode_ready_o));
      // capture stays active through the cycle that writes the filling sample
      check_value("capture_active while sending",
                  int'(started && (!model_full || cycle_cnt - fill_cycle <= 1)),
                  int'(capture_active_o));
      if (in_ready_o) begin
        taken = 1'b1;
        if (started) begin
          record_sample(ch, val, row);
        end
      end
    end
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #1;
    in_valid_i = 1'b0;
    start_i    = 1'b1;
    @(posedge clk);
    #1;
    start_i = 1'b0;
    started = 1'b1;
    @(negedge clk);
    check_value("capture_active after start", 1, int'(capture_active_o));
  endtask

  // without a stop the region fill must already have ended capture
  task automatic end_capture(input int row);
    @(posedge clk);
    #1;
    in_valid_i = 1'b0;
    if (row_stop[row]) begin
      stop_i = 1'b1;
      @(posedge clk);
      #1;
      stop_i = 1'b0;
    end
    @(negedge clk);
    check_value("capture_active after end", 0, int'(capture_active_o));
  endtask

  task automatic build_expected(input int row);
    int n_en;
    int c;
    int k;
    exp_q.delete();
    n_en = 1 << row_mode[row];
    for (c = 0; c < n_en; c++) begin
      exp_q.push_back(16'(c));
      exp_q.push_back(16'(model_cnt[c]));
      for (k = 0; k < model_cnt[c]; k++) begin
        exp_q.push_back(model_mem[c][k]);
      end
    end
  endtask

  task automatic read_out(input bit toggle);
    int idx;
    int total;
    idx   = 0;
    total = exp_q.size();
    while (idx < total) begin
      @(posedge clk);
      #1;
      out_ready_i = toggle ? 1'($random(seed)) : 1'b1;
      @(negedge clk);
      if (out_valid_o && out_ready_i) begin
        check_value("word", int'(exp_q[idx]), int'(out_data_o));
        check_value("last", int'(idx == total - 1), int'(out_last_o));
        check_value("mode_ready in readout", 0, int'(mode_ready_o));
        idx++;
      end
    end
    @(posedge clk);
    #1;
    out_ready_i = 1'b0;
    while (!mode_ready_o) begin
      @(negedge clk);
    end
    started = 1'b0;
    @(negedge clk);
    check_value("out_valid after last", 0, int'(out_valid_o));
  endtask

  initial begin
    repeat (n_rows * 600 + 200) @(posedge clk);
    $display("timeout: the run did not finish in the expected number of cycles");
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int r;
    int i;
    int gap;
    reset_i      = 1'b1;
    mode_i       = mode_one;
    mode_valid_i = 1'b0;
    start_i      = 1'b0;
    stop_i       = 1'b0;
    in_valid_i   = 1'b0;
    in_channel_i = '0;
    in_data_i    = '0;
    out_ready_i  = 1'b0;
    started      = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    reset_i = 1'b0;
    @(negedge clk);
    test_name = "reset";
    check_value("out_valid", 0, int'(out_valid_o));
    check_value("out_last", 0, int'(out_last_o));
    check_value("capture_active", 0, int'(capture_active_o));
    check_value("in_ready", 1, int'(in_ready_o));
    check_value("mode_ready", 1, int'(mode_ready_o));

    for (r = 0; r < n_rows; r++) begin
      test_name = row_name[r];
      for (i = 0; i < 4; i++) begin
        model_cnt[i] = 0;
      end
      model_full = 1'b0;
      apply_mode(bank_mode_e'(row_mode[r]));
      // samples sent while idle must never reach the output
      for (i = 0; i < 3; i++) begin
        send_sample(i, 16'($random(seed)), r);
      end
      pulse_start();
      for (i = 0; i < row_per_chan[r] * 4; i++) begin
        if (row_gaps[r]) begin
          gap = $random(seed) & 3;
          idle_cycles(gap);
        end
        send_sample(i % 4, 16'($random(seed)), r);
      end
      end_capture(r);
      build_expected(r);
      read_out(row_toggle[r]);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* sample_buffer.f */
buffer_cfg_pkg.sv
buffer_types_pkg.sv
mem_port_if.sv
sample_memory.sv
mem_arbiter.sv
capture_writer.sv
readout_reader.sv
sample_buffer.sv
sample_buffer_tb.sv

/* Makefile */
TOP = sample_buffer_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sample_buffer.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sample_buffer.f

clean:
	rm -rf obj_dir $(LOG)
